// ==== Makefile ====
# Verilator build and run of the fp24 rsqrt unit testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_fp24_rsqrt_unit
FILELIST  ?= fp24_rsqrt_unit.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== fp24_rsqrt_unit.f ====
+incdir+sim
verilog/fp24_pkg.sv
verilog/fp24_mult.sv
verilog/fp24_nr_correction.sv
verilog/fp24_inv_sqrt_stage.sv
verilog/fp24_inv_sqrt.sv
verilog/fp24_rsqrt_unit.sv
sim/tb_fp24_rsqrt_unit.sv

// ==== sim/tb_fp24_model.svh ====
// reference rsqrt model and fp24 real conversions, included inside the testbench module
`ifndef TB_FP24_MODEL_SVH
`define TB_FP24_MODEL_SVH

  // zero exponent reads as zero, denormals are flushed
  function automatic real fp24_to_real(input fp24 v);
    real mag;
    int  e;
    if (v.exp == 7'd0) begin
      return 0.0;
    end
    mag = 1.0 + real'(v.frac) / 65536.0;
    e   = int'(v.exp) - 63;
    for (int i = 0; i < e; i++) begin
      mag = mag * 2.0;
    end
    for (int i = 0; i > e; i--) begin
      mag = mag / 2.0;
    end
    return v.sign ? -mag : mag;
  endfunction

  // positive normals only, fraction truncated
  function automatic fp24 real_to_fp24(input real r);
    real m;
    int  e;
    fp24 v;
    m = r;
    e = 0;
    while (m >= 2.0) begin
      m = m / 2.0;
      e++;
    end
    while (m < 1.0) begin
      m = m * 2.0;
      e--;
    end
    v.sign = 1'b0;
    v.exp  = 7'(e + 63);
    v.frac = 16'($rtoi((m - 1.0) * 65536.0));
    return v;
  endfunction

  // nan, then zero, then negative, then infinity
  function automatic fp24 expected_result(input fp24 op);
    if (op.exp == 7'h7f && op.frac != 16'd0) begin
      return fp24_qnan;
    end
    if (op.exp == 7'd0) begin
      return fp24_pos_inf;
    end
    if (op.sign) begin
      return fp24_qnan;
    end
    if (op.exp == 7'h7f) begin
      return fp24_zero;
    end
    return real_to_fp24(1.0 / $sqrt(fp24_to_real(op)));
  endfunction

  function automatic logic expected_invalid(input fp24 op);
    return (op.exp == 7'h7f && op.frac != 16'd0) || (op.exp != 7'd0 && op.sign);
  endfunction

  // specials are exact, normals within a relative error of 2^-10
  function automatic logic value_ok(input fp24 op, input fp24 res);
    real want;
    real err;
    if (op.sign || op.exp == 7'd0 || op.exp == 7'h7f) begin
      return res == expected_result(op);
    end
    want = 1.0 / $sqrt(fp24_to_real(op));
    err  = (fp24_to_real(res) - want) / want;
    return !res.sign && err <= 0.0009765625 && err >= -0.0009765625;
  endfunction

`endif

// ==== sim/tb_fp24_rsqrt_unit.sv ====
// testbench for the fp24 rsqrt unit, streams operands and checks each result beat with assertions
`timescale 1ns/1ns

module tb_fp24_rsqrt_unit;
  import fp24_pkg::*;

  logic  clk;
  logic  rst;
  fp24   operand;
  logic  operand_valid;
  fp24   result;
  logic  result_valid;
  logic  invalid;

  // operands waiting for their result, oldest first
  fp24   op_q [$];
  fp24   head_op;
  logic  have_head;
  // beat seen between edges, checked at the next rising edge
  logic  beat_pending;
  fp24   beat_result;
  logic  beat_invalid;
  string test_name;
  int    error_count;
  int    test_count;
  int    checked_count;
  int    sent;
  int    beats;
  int    errors_at_start;

  // zeros, denormal, infinities, a normal, negatives, nans
  logic [23:0] special_ops [0:10] = '{24'h000000, 24'h800000, 24'h001234, 24'h7f0000,
                                      24'h3f0000, 24'hff0000, 24'hbf4000, 24'hc12345,
                                      24'h7f0001, 24'hff8000, 24'h7f8000};

  `include "tb_fp24_model.svh"

  fp24_rsqrt_unit u_fp24_rsqrt_unit (
    .clk           (clk),
    .rst           (rst),
    .operand       (operand),
    .operand_valid (operand_valid),
    .result        (result),
    .result_valid  (result_valid),
    .invalid       (invalid)
  );

  always #50 clk = ~clk;

  task automatic note_failure(input string msg);
    $display("%s: %s", test_name, msg);
    error_count++;
  endtask

  task automatic report_value();
    $display("[ERROR] %s: result expected %h, actual %h, operand %h",
             test_name, expected_result(head_op), beat_result, head_op);
    error_count++;
  endtask

  task automatic report_flag();
    $display("[ERROR] %s: invalid expected %b, actual %b, operand %h",
             test_name, expected_invalid(head_op), beat_invalid, head_op);
    error_count++;
  endtask

  task automatic refresh_head();
    have_head = (op_q.size() > 0);
    if (have_head) begin
      head_op = op_q[0];
    end
  endtask

  // retire a beat at the negedge after its check
  // so the head stays on the checked operand through the edge
  always @(negedge clk) begin
    if (beat_pending) begin
      if (op_q.size() > 0) begin
        void'(op_q.pop_front());
      end
      beats++;
      checked_count++;
      refresh_head();
    end
    beat_pending = !rst && result_valid;
    beat_result  = result;
    beat_invalid = invalid;
  end

  // every accepted operand comes back exactly 13 cycles later
  assert property (@(posedge clk) disable iff (rst)
    operand_valid |-> ##(rsqrt_latency) result_valid)
    else note_failure("result_valid missing 13 cycles after an accepted operand");

  // no beat without an operand 13 cycles earlier and one waiting in the queue
  assert property (@(posedge clk) disable iff (rst)
    result_valid |-> ($past(operand_valid, rsqrt_latency) && have_head))
    else note_failure("result_valid high with no matching operand");

  assert property (@(posedge clk) disable iff (rst)
    (result_valid && have_head) |-> value_ok(head_op, result))
    else report_value();

  assert property (@(posedge clk) disable iff (rst)
    (result_valid && have_head) |-> (invalid == expected_invalid(head_op)))
    else report_flag();

  // inputs change just after the rising edge
  task automatic send(input fp24 op);
    @(posedge clk);
    #1;
    operand       = op;
    operand_valid = 1'b1;
    op_q.push_back(op);
    sent++;
    refresh_head();
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
      operand_valid = 1'b0;
    end
  endtask

  // exponent kept where y*y and x*y*y stay in range
  function automatic fp24 random_normal();
    fp24 v;
    v.sign = 1'b0;
    v.exp  = 7'(4 + $urandom % 119);
    v.frac = 16'($urandom);
    return v;
  endfunction

  task automatic start_test(input string name);
    test_name       = name;
    sent            = 0;
    beats           = 0;
    errors_at_start = error_count;
  endtask

  task automatic finish_test();
    int waited;
    waited = 0;
    idle(1);
    while (op_q.size() != 0 && waited < rsqrt_latency + 8) begin
      @(posedge clk);
      waited++;
    end
    if (op_q.size() != 0) begin
      note_failure("timed out waiting for outstanding results");
      op_q.delete();
      refresh_head();
    end
    assert (beats == sent)
      else note_failure($sformatf("%0d results for %0d operands", beats, sent));
    test_count++;
    $display("%s done: %0d operands, %0d results, %0d errors",
             test_name, sent, beats, error_count - errors_at_start);
  endtask

  initial begin
    void'($urandom(32'h0183_a5fa));
    clk           = 1'b0;
    rst           = 1'b1;
    operand       = '0;
    operand_valid = 1'b0;
    head_op       = '0;
    have_head     = 1'b0;
    beat_pending  = 1'b0;
    test_name     = "reset";
    error_count   = 0;
    test_count    = 0;
    checked_count = 0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    // isolated operands, one beat each
    start_test("latency");
    repeat (4) begin
      send(random_normal());
      idle(20);
    end
    finish_test();

    start_test("accuracy");
    repeat (300) begin
      send(random_normal());
    end
    finish_test();

    start_test("special");
    foreach (special_ops[i]) begin
      send(special_ops[i]);
    end
    finish_test();

    // full-rate burst, then bubbles with specials mixed in
    start_test("streaming");
    repeat (150) begin
      send(random_normal());
    end
    for (int i = 0; i < 150; i++) begin
      if ($urandom % 3 == 0) begin
        idle(1 + $urandom % 3);
      end
      if (i % 10 == 0) begin
        send(special_ops[(i / 10) % 11]);
      end else begin
        send(random_normal());
      end
    end
    finish_test();

    // flush mid-flight, then nothing may come out until new operands
    start_test("reset");
    repeat (6) begin
      send(random_normal());
    end
    @(posedge clk);
    #1;
    rst           = 1'b1;
    operand_valid = 1'b0;
    op_q.delete();
    refresh_head();
    sent = 0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    idle(20);
    repeat (5) begin
      send(random_normal());
    end
    finish_test();

    $display("tests: %0d, results checked: %0d, errors: %0d",
             test_count, checked_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== verilog/fp24_inv_sqrt.sv ====
// reciprocal square root pipeline, magic-constant seed plus newton stages, 13 cycles x to y
`timescale 1ns/1ns

module fp24_inv_sqrt (
  input  logic          clk,
  input  logic          rst,
  input  fp24_pkg::fp24 x,
  input  logic          x_valid,
  output fp24_pkg::fp24 y,
  output logic          y_valid
);
  import fp24_pkg::*;

  // estimate at every stage boundary
  // entry 0 is the registered seed, last entry is the final result
  fp24 y_stage [0:nr_stage_count];
  // x_dly[k] is x delayed k+1 cycles
  fp24 x_dly [0:rsqrt_latency-1];
  logic [rsqrt_latency-1:0] valid_dly;
  logic [23:0] seed;

  // bit trick: shift halves and negates the exponent
  assign seed = rsqrt_seed_magic - (x >> 1);

  // seed and operand delay, data only
  always_ff @(posedge clk) begin
    y_stage[0] <= seed;
    x_dly[0]   <= x;
    for (int i = 1; i < rsqrt_latency; i++) begin
      x_dly[i] <= x_dly[i - 1];
    end
  end

  // valid shift register
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_dly <= '0;
    end else begin
      valid_dly <= {valid_dly[rsqrt_latency-2:0], x_valid};
    end
  end

  // stage i starts 1 + 4i cycles after x
  // so it taps x_dly[4i]
  for (genvar i = 0; i < nr_stage_count; i++) begin : g_stage
    fp24_inv_sqrt_stage u_stage (
      .clk    (clk),
      .rst    (rst),
      .x      (x_dly[i * nr_stage_latency]),
      .y      (y_stage[i]),
      .y_next (y_stage[i + 1])
    );
  end

  assign y       = y_stage[nr_stage_count];
  assign y_valid = valid_dly[rsqrt_latency-1];

  // pipeline drains completely on reset
  assert property (@(posedge clk)
    (rst ##1 !rst) |-> !y_valid [*rsqrt_latency]);

endmodule

// ==== verilog/fp24_inv_sqrt_stage.sv ====
// one newton-raphson step y' = y * (3 - x*y*y) / 2, four cycles from y to y_next
`timescale 1ns/1ns

module fp24_inv_sqrt_stage (
  input  logic          clk,
  input  logic          rst,
  input  fp24_pkg::fp24 x,
  input  fp24_pkg::fp24 y,
  output fp24_pkg::fp24 y_next
);
  import fp24_pkg::*;

  // cycle 1 result
  fp24 y_sq;
  // operand held one cycle to meet y_sq
  fp24 x_q;
  // cycle 2 result
  fp24 xy_sq;
  // cycle 3 result
  fp24 corr;
  // y held until corr is ready
  fp24 y_dly [0:2];

  always_ff @(posedge clk) begin
    x_q      <= x;
    y_dly[0] <= y;
    y_dly[1] <= y_dly[0];
    y_dly[2] <= y_dly[1];
  end

  // y * y
  fp24_mult u_mult_y_sq (
    .clk  (clk),
    .a    (y),
    .b    (y),
    .prod (y_sq)
  );

  // x * y * y
  fp24_mult u_mult_x (
    .clk  (clk),
    .a    (y_sq),
    .b    (x_q),
    .prod (xy_sq)
  );

  // (3 - x*y*y) / 2
  fp24_nr_correction u_nr_correction (
    .clk  (clk),
    .p    (xy_sq),
    .corr (corr)
  );

  // scale the old estimate
  fp24_mult u_mult_y (
    .clk  (clk),
    .a    (corr),
    .b    (y_dly[2]),
    .prod (y_next)
  );

endmodule

// ==== verilog/fp24_mult.sv ====
// registered fp24 multiplier, one cycle from a and b to prod, truncating
`timescale 1ns/1ns

module fp24_mult (
  input  logic          clk,
  input  fp24_pkg::fp24 a,
  input  fp24_pkg::fp24 b,
  output fp24_pkg::fp24 prod
);
  import fp24_pkg::*;

  // significands with hidden one
  logic [16:0] sig_a;
  logic [16:0] sig_b;
  // 1.x * 1.x lands in [1, 4)
  logic [33:0] sig_prod;
  // biased sum, still carries one extra bias
  logic [8:0]  exp_raw;
  logic [8:0]  exp_out;
  logic        sign_out;
  fp24         prod_d;

  assign sig_a    = {1'b1, a.frac};
  assign sig_b    = {1'b1, b.frac};
  assign sig_prod = sig_a * sig_b;
  assign sign_out = a.sign ^ b.sign;

  // top bit set means product >= 2, one place of normalization
  assign exp_raw = {2'b00, a.exp} + {2'b00, b.exp} + {8'b0, sig_prod[33]};
  assign exp_out = exp_raw - {2'b00, fp24_exp_bias};

  always_comb begin
    prod_d.sign = sign_out;
    if (a.exp == 7'd0 || b.exp == 7'd0 || exp_raw <= {2'b00, fp24_exp_bias}) begin
      // zero operand or underflow
      // flush to signed zero
      prod_d.exp  = 7'd0;
      prod_d.frac = 16'd0;
    end else if (a.exp == fp24_exp_max || b.exp == fp24_exp_max ||
                 exp_raw >= {2'b00, fp24_exp_bias} + {2'b00, fp24_exp_max}) begin
      // inf operand or overflow
      // saturate to signed infinity
      prod_d.exp  = fp24_exp_max;
      prod_d.frac = 16'd0;
    end else begin
      prod_d.exp = exp_out[6:0];
      // drop hidden one, truncate the rest
      if (sig_prod[33]) begin
        prod_d.frac = sig_prod[32:17];
      end else begin
        prod_d.frac = sig_prod[31:16];
      end
    end
  end

  // output register
  always_ff @(posedge clk) begin
    prod <= prod_d;
  end

endmodule

// ==== verilog/fp24_nr_correction.sv ====
// registered newton correction factor (3 - p) / 2, one cycle of latency, result never negative
`timescale 1ns/1ns

module fp24_nr_correction (
  input  logic          clk,
  input  fp24_pkg::fp24 p,
  output fp24_pkg::fp24 corr
);
  import fp24_pkg::*;

  // 20-bit fixed point, bit 19 weighs 2^1 (exponent of 3.0)
  // three low guard bits keep a little extra precision through alignment
  logic [19:0] three_al;
  logic [19:0] p_sig;
  logic [19:0] p_al;
  logic [6:0]  shift;
  logic [20:0] diff;
  logic        diff_neg;
  logic [4:0]  lz;
  logic [19:0] norm;
  fp24         corr_d;

  // leading zero count, 20 when v is zero
  function automatic logic [4:0] lead_zeros(input logic [19:0] v);
    logic [4:0] n;
    n = 5'd20;
    // highest set bit wins since loop walks upward
    for (int i = 0; i < 20; i++) begin
      if (v[i]) begin
        n = 5'(19 - i);
      end
    end
    return n;
  endfunction

  assign three_al = {1'b1, fp24_three.frac, 3'b000};
  assign p_sig    = {1'b1, p.frac, 3'b000};
  // only valid when p.exp <= exp of 3.0
  assign shift    = fp24_three.exp - p.exp;

  always_comb begin
    if (p.exp == 7'd0 || p.sign) begin
      // zero product, correction is 1.5
      // negative p only comes from negative operands, overridden at the top
      p_al = 20'd0;
    end else begin
      // shifts of 20 or more leave nothing
      p_al = p_sig >> shift;
    end
  end

  assign diff = {1'b0, three_al} - {1'b0, p_al};

  // p >= 4 or p in (3, 4) means the estimate diverged
  assign diff_neg = (!p.sign && p.exp > fp24_three.exp) || diff[20];

  assign lz   = lead_zeros(diff[19:0]);
  assign norm = diff[19:0] << lz;

  always_comb begin
    corr_d.sign = 1'b0;
    if (diff_neg || diff[19:0] == 20'd0) begin
      // clamp to zero
      corr_d.exp  = 7'd0;
      corr_d.frac = 16'd0;
    end else begin
      // leading one at bit 19 is 2^1, halving gives 2^0 = bias
      corr_d.exp  = fp24_exp_bias - {2'b00, lz};
      corr_d.frac = norm[18:3];
    end
  end

  always_ff @(posedge clk) begin
    corr <= corr_d;
  end

  // factor stays within [0, 1.5] once data is flowing
  assert property (@(posedge clk) !$isunknown(corr) |->
    (!corr.sign && {corr.exp, corr.frac} <= {fp24_exp_bias, 16'h8000}));

endmodule

// ==== verilog/fp24_pkg.sv ====
// fp24 format fields, special constants, operand classes and pipeline latencies for the rsqrt unit
package fp24_pkg;

  // sign, biased exponent, fraction with hidden leading one
  typedef struct packed {
    logic        sign;
    logic [6:0]  exp;
    logic [15:0] frac;
  } fp24;

  // exponent encoding
  localparam logic [6:0] fp24_exp_bias = 7'd63;
  // all ones marks infinity and nan
  localparam logic [6:0] fp24_exp_max  = 7'h7f;

  // 3.0 = 1.5 * 2^1
  localparam fp24 fp24_three = 24'h408000;

  // canonical special results
  localparam fp24 fp24_pos_inf = 24'h7f0000;
  localparam fp24 fp24_qnan    = 24'h7f8000;
  localparam fp24 fp24_zero    = 24'h000000;

  // seed = magic - (x >> 1)
  // exponent halving falls out of the shift
  localparam logic [23:0] rsqrt_seed_magic = 24'h5e7a09;

  // newton refinement depth
  localparam integer nr_stage_count   = 3;
  // cycles per newton stage
  localparam integer nr_stage_latency = 4;
  // seed register plus all stages
  localparam integer rsqrt_latency    = 1 + nr_stage_count * nr_stage_latency;

  // operand screening result
  typedef enum logic [2:0] {
    cls_normal,
    cls_zero,
    cls_inf,
    cls_nan,
    cls_negative
  } fp24_class_e;

endpackage

// ==== verilog/fp24_rsqrt_unit.sv ====
// top level rsqrt unit, screens special operands and overrides pipeline results, 13-cycle stream
`timescale 1ns/1ns

module fp24_rsqrt_unit (
  input  logic          clk,
  input  logic          rst,
  input  fp24_pkg::fp24 operand,
  input  logic          operand_valid,
  output fp24_pkg::fp24 result,
  output logic          result_valid,
  output logic          invalid
);
  import fp24_pkg::*;

  fp24_class_e cls_in;
  // class travels beside the pipeline, entry 12 lines up with y
  fp24_class_e cls_dly [0:rsqrt_latency-1];
  fp24         y;
  logic        y_valid;

  // classification order matters
  // nan first, then zero (covers -0 and denormals), then negative
  always_comb begin
    if (operand.exp == fp24_exp_max && operand.frac != 16'd0) begin
      cls_in = cls_nan;
    end else if (operand.exp == 7'd0) begin
      // denormals flush to zero
      cls_in = cls_zero;
    end else if (operand.sign) begin
      // includes -inf
      cls_in = cls_negative;
    end else if (operand.exp == fp24_exp_max) begin
      cls_in = cls_inf;
    end else begin
      cls_in = cls_normal;
    end
  end

  // advances every cycle, valid comes from the pipeline
  always_ff @(posedge clk) begin
    cls_dly[0] <= cls_in;
    for (int i = 1; i < rsqrt_latency; i++) begin
      cls_dly[i] <= cls_dly[i - 1];
    end
  end

  fp24_inv_sqrt u_inv_sqrt (
    .clk     (clk),
    .rst     (rst),
    .x       (operand),
    .x_valid (operand_valid),
    .y       (y),
    .y_valid (y_valid)
  );

  // override on the last stage, no extra register
  always_comb begin
    invalid = 1'b0;
    case (cls_dly[rsqrt_latency-1])
      cls_zero: result = fp24_pos_inf;
      cls_inf:  result = fp24_zero;
      cls_nan, cls_negative: begin
        result  = fp24_qnan;
        invalid = y_valid;
      end
      default:  result = y;
    endcase
  end

  assign result_valid = y_valid;

  // flag only on a live beat whose operand screened as nan or negative
  // class line and valid line must stay the same length
  assert property (@(posedge clk) disable iff (rst)
    invalid |-> (result_valid &&
                 ($past(cls_in, rsqrt_latency) == cls_nan ||
                  $past(cls_in, rsqrt_latency) == cls_negative)));

endmodule
